// ==== mole_pkg.sv ====
package mole_pkg;

	////////////////////////////////////////////////////////////
	// widths
	////////////////////////////////////////////////////////////

	localparam int PAD_W  = 8;  // one bit per direction pad
	localparam int LOC_W  = 3;  // eight mole holes
	localparam int ADDR_W = 23; // music sample address
	localparam int IDX_W  = 7;  // table slot / item count
	localparam int HOLD_W = 2;  // hold-off tick counter

	// pad order, msb first: upleft up upright left right downleft down downright
	typedef logic [PAD_W-1:0]  pad_bits_t;
	typedef logic [LOC_W-1:0]  mole_loc_t;
	typedef logic [ADDR_W-1:0] music_addr_t;
	typedef logic [IDX_W-1:0]  item_idx_t;
	typedef logic [HOLD_W-1:0] hold_cnt_t;

	////////////////////////////////////////////////////////////
	// limits
	////////////////////////////////////////////////////////////

	localparam item_idx_t MAX_ITEMS  = 7'd127; // table capacity, recording stops here
	localparam hold_cnt_t HOLD_TICKS = 2'd2;   // one-hertz ticks between counted presses

	// recording fsm
	typedef enum logic [2:0] {
		diy_idle      = 3'd0, // waiting for diy mode, music and up
		diy_arm       = 3'd1, // entered, one cycle before taking presses
		diy_start     = 3'd2, // taking presses
		diy_hold      = 3'd3, // hold-off after a press
		diy_hold_done = 3'd4,
		diy_done      = 3'd5, // music ended or table full
		diy_playback  = 3'd6
	} diy_state_t;

	////////////////////////////////////////////////////////////
	// mole locations, one per pad
	////////////////////////////////////////////////////////////

	localparam mole_loc_t LOC_UPLEFT    = 3'd0;
	localparam mole_loc_t LOC_UP        = 3'd1;
	localparam mole_loc_t LOC_UPRIGHT   = 3'd2;
	localparam mole_loc_t LOC_LEFT      = 3'd3;
	localparam mole_loc_t LOC_RIGHT     = 3'd4;
	localparam mole_loc_t LOC_DOWNLEFT  = 3'd5;
	localparam mole_loc_t LOC_DOWN      = 3'd6;
	localparam mole_loc_t LOC_DOWNRIGHT = 3'd7;

endpackage

// ==== pad_capture.sv ====
`timescale 1ns/1ps

module pad_capture (
	input  logic                clock,
	input  logic                reset,
	input  logic                upleft,
	input  logic                up,
	input  logic                upright,
	input  logic                left,
	input  logic                right,
	input  logic                downleft,
	input  logic                down,
	input  logic                downright,
	output logic                press,     // one-cycle pulse per new single press
	output mole_pkg::mole_loc_t press_loc, // valid with press
	output logic                up_level
);
	import mole_pkg::*;

	pad_bits_t pad_now;    // live pad levels, packed
	pad_bits_t pad_cur;    // sample from this edge
	pad_bits_t pad_prev;   // sample from the edge before
	pad_bits_t pad_new;    // bits that went high between the two samples
	logic      single_new; // qualified press, before the output register
	mole_loc_t loc_enc;

	assign pad_now  = {upleft, up, upright, left, right, downleft, down, downright};
	assign up_level = up; // fsm entry looks at the raw level

	////////////////////////////////////////////////////////////
	// sample history
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			pad_cur  <= '0;
			pad_prev <= '0;
		end else begin
			pad_cur  <= pad_now;
			pad_prev <= pad_cur;
		end
	end

	// exactly one pad down now, and it was up before
	// previous sample idle or a single pad, so a messy chord release is ignored
	assign pad_new    = pad_cur & ~pad_prev;
	assign single_new = $onehot(pad_cur) && $onehot0(pad_prev) && (pad_new == pad_cur);

	// one-hot pad to hole number
	always_comb begin
		case (pad_cur)
			8'b1000_0000: loc_enc = LOC_UPLEFT;
			8'b0100_0000: loc_enc = LOC_UP;
			8'b0010_0000: loc_enc = LOC_UPRIGHT;
			8'b0001_0000: loc_enc = LOC_LEFT;
			8'b0000_1000: loc_enc = LOC_RIGHT;
			8'b0000_0100: loc_enc = LOC_DOWNLEFT;
			8'b0000_0010: loc_enc = LOC_DOWN;
			8'b0000_0001: loc_enc = LOC_DOWNRIGHT;
			default:      loc_enc = LOC_UPLEFT; // not a single press, press stays low
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) press <= 1'b0;
		else press <= single_new;
	end

	always_ff @(posedge clock) begin
		if (single_new) press_loc <= loc_enc; // only meaningful while press is high
	end

endmodule

// ==== diy_sequencer.sv ====
`timescale 1ns/1ps

module diy_sequencer (
	input  logic                 clock,
	input  logic                 reset,
	input  logic                 diy_mode,
	input  logic                 bram_loaded,
	input  logic                 up_level,
	input  logic                 diy_playback,  // level, selects playback once done
	input  logic                 diy_music_end,
	input  logic                 one_hz_enable,
	input  logic                 press,
	input  mole_pkg::mole_loc_t  press_loc,
	output logic                 table_we,
	output mole_pkg::item_idx_t  table_waddr,
	output mole_pkg::mole_loc_t  table_loc,
	output mole_pkg::item_idx_t  items,
	output logic                 ready_to_use,
	output logic                 diy_playback_mode,
	output mole_pkg::diy_state_t state
);
	import mole_pkg::*;

	// the port diy_playback hides the enum value, so the state is named with its package

	diy_state_t next_state;
	hold_cnt_t  hold_cnt;   // ticks seen since the last accepted press
	logic       hold_over;  // last hold-off tick arrives
	logic       accept;     // this edge stores an entry

	assign hold_over = (state == diy_hold) && one_hz_enable &&
		(hold_cnt == hold_cnt_t'(HOLD_TICKS - 2'd1));

	assign accept = (state == diy_start) && diy_mode && !ready_to_use && press &&
		(items < MAX_ITEMS); // never wrap the slot index

	// write port, address sampled by the table on the same edge
	assign table_we    = accept;
	assign table_waddr = items;   // next free slot
	assign table_loc   = press_loc;

	////////////////////////////////////////////////////////////
	// next state
	////////////////////////////////////////////////////////////

	always_comb begin
		next_state = state;
		case (state)
			diy_idle: begin
				if (diy_mode && bram_loaded && up_level) next_state = diy_arm;
			end
			diy_arm, diy_hold_done: begin
				if (!diy_mode) next_state = diy_idle;
				else if (ready_to_use) next_state = diy_done;
				else next_state = diy_start;
			end
			diy_start: begin
				if (!diy_mode) next_state = diy_idle;
				else if (ready_to_use) next_state = diy_done;
				else if (accept) next_state = diy_hold;
			end
			diy_hold: begin
				if (!diy_mode) next_state = diy_idle;
				else if (ready_to_use) next_state = diy_done;
				else if (hold_over) next_state = diy_hold_done;
			end
			diy_done, mole_pkg::diy_playback: begin
				// follows the playback level, one cycle late
				if (!diy_mode) next_state = diy_idle;
				else if (diy_playback) next_state = mole_pkg::diy_playback;
				else next_state = diy_done;
			end
			default: next_state = diy_idle;
		endcase
	end

	////////////////////////////////////////////////////////////
	// registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state             <= diy_idle;
			diy_playback_mode <= 1'b0;
		end else begin
			state             <= next_state;
			diy_playback_mode <= (next_state == mole_pkg::diy_playback); // tracks the state exactly
		end
	end

	// item count, emptied on the way into idle
	always_ff @(posedge clock) begin
		if (reset) items <= '0;
		else if (next_state == diy_idle) items <= '0;
		else if (accept) items <= items + 7'd1;
	end

	// hold-off tick counter
	always_ff @(posedge clock) begin
		if (reset) hold_cnt <= '0;
		else if (accept) hold_cnt <= '0;              // restart on each press
		else if (state == diy_hold && one_hz_enable) hold_cnt <= hold_cnt + 2'd1;
	end

	// done flag, one cycle behind music end or a full table
	always_ff @(posedge clock) begin
		if (reset) ready_to_use <= 1'b0;
		else ready_to_use <= diy_music_end || (items >= MAX_ITEMS);
	end

endmodule

// ==== mole_table.sv ====
`timescale 1ns/1ps

module mole_table (
	input  logic                  clock,
	input  logic                  table_we,
	input  mole_pkg::item_idx_t   table_waddr,
	input  mole_pkg::mole_loc_t   table_loc,
	input  mole_pkg::music_addr_t music_address, // captured on the write edge
	input  mole_pkg::item_idx_t   lookup_index,
	output mole_pkg::mole_loc_t   index_location,
	output mole_pkg::music_addr_t index_address
);
	import mole_pkg::*;

	////////////////////////////////////////////////////////////
	// entry storage, one slot per recorded press
	////////////////////////////////////////////////////////////

	music_addr_t addr_mem [0:MAX_ITEMS-1]; // music address per slot
	mole_loc_t   loc_mem  [0:MAX_ITEMS-1]; // hole per slot

	// single write port, both arrays together
	always_ff @(posedge clock) begin
		if (table_we) begin
			addr_mem[table_waddr] <= music_address;
			loc_mem[table_waddr]  <= table_loc;
		end
	end

	// lookup port, one cycle latency
	always_ff @(posedge clock) begin
		index_address  <= addr_mem[lookup_index];
		index_location <= loc_mem[lookup_index];
	end

endmodule

// ==== mole_recorder_top.sv ====
`timescale 1ns/1ps

module mole_recorder_top (
	input  logic                  clock,
	input  logic                  reset,
	input  logic                  upleft,
	input  logic                  up,
	input  logic                  upright,
	input  logic                  left,
	input  logic                  right,
	input  logic                  downleft,
	input  logic                  down,
	input  logic                  downright,
	input  logic                  diy_mode,
	input  logic                  diy_playback,
	input  logic                  bram_loaded,
	input  logic                  diy_music_end,
	input  logic                  one_hz_enable,  // one-cycle tick
	input  mole_pkg::music_addr_t music_address,
	input  mole_pkg::item_idx_t   lookup_index,
	output logic                  ready_to_use,
	output mole_pkg::item_idx_t   items,
	output mole_pkg::mole_loc_t   index_location,
	output mole_pkg::music_addr_t index_address,
	output logic                  diy_playback_mode,
	output mole_pkg::diy_state_t  state
);
	import mole_pkg::*;

	logic      press;       // pad side to sequencer
	mole_loc_t press_loc;
	logic      up_level;
	logic      table_we;    // sequencer to table
	item_idx_t table_waddr;
	mole_loc_t table_loc;

	////////////////////////////////////////////////////////////
	// pads in, sequencer, table out
	////////////////////////////////////////////////////////////

	pad_capture u_pads (
		.clock(clock), .reset(reset),
		.upleft(upleft), .up(up), .upright(upright), .left(left),
		.right(right), .downleft(downleft), .down(down), .downright(downright),
		.press(press), .press_loc(press_loc), .up_level(up_level)
	);

	diy_sequencer u_seq (
		.clock(clock), .reset(reset),
		.diy_mode(diy_mode), .bram_loaded(bram_loaded), .up_level(up_level),
		.diy_playback(diy_playback), .diy_music_end(diy_music_end),
		.one_hz_enable(one_hz_enable),
		.press(press), .press_loc(press_loc),
		.table_we(table_we), .table_waddr(table_waddr), .table_loc(table_loc),
		.items(items), .ready_to_use(ready_to_use),
		.diy_playback_mode(diy_playback_mode), .state(state)
	);

	// music address goes straight to the table
	mole_table u_table (
		.clock(clock),
		.table_we(table_we), .table_waddr(table_waddr), .table_loc(table_loc),
		.music_address(music_address),
		.lookup_index(lookup_index),
		.index_location(index_location), .index_address(index_address)
	);

endmodule

// ==== mole_recorder_assert.sv ====
`timescale 1ns/1ps

module mole_recorder_assert (
	input logic                 clock,
	input logic                 reset,
	input logic                 ready_to_use,
	input logic                 diy_playback_mode,
	input mole_pkg::item_idx_t  items,
	input mole_pkg::diy_state_t state
);
	import mole_pkg::*;

	int fail_count = 0; // assertion failures so far

	// mode flag mirrors the playback state
	a_playback_only: assert property (@(posedge clock) disable iff (reset)
		diy_playback_mode |-> (state == mole_pkg::diy_playback))
		else begin
			$error("diy_playback_mode high outside diy_playback");
			fail_count++;
		end

	// a full count stays put until idle empties it, so it never wraps past capacity
	a_items_max: assert property (@(posedge clock) disable iff (reset)
		(items == MAX_ITEMS) |=> (items == MAX_ITEMS || state == diy_idle))
		else begin
			$error("items above table capacity");
			fail_count++;
		end

	// flags cleared by reset
	a_reset_clear: assert property (@(posedge clock)
		reset |=> (!ready_to_use && !diy_playback_mode))
		else begin
			$error("flags not cleared after reset");
			fail_count++;
		end

endmodule

bind mole_recorder_top mole_recorder_assert u_assert (
	.clock(clock), .reset(reset), .ready_to_use(ready_to_use),
	.diy_playback_mode(diy_playback_mode), .items(items), .state(state)
);

// ==== tb_mole_recorder.sv ====
`timescale 1ns/1ps

module tb_mole_recorder;
	import mole_pkg::*;

	logic        clock;
	logic        reset;
	pad_bits_t   pads;           // upleft in the msb, downright in the lsb
	logic        diy_mode;
	logic        playback_level; // drives the diy_playback port
	logic        bram_loaded;
	logic        diy_music_end;
	logic        one_hz_enable;
	music_addr_t music_address;
	item_idx_t   lookup_index;
	logic        ready_to_use;
	item_idx_t   items;
	mole_loc_t   index_location;
	music_addr_t index_address;
	logic        diy_playback_mode;
	diy_state_t  state;

	mole_loc_t   exp_loc [0:MAX_ITEMS-1]; // reference table
	music_addr_t exp_addr [0:MAX_ITEMS-1];
	int          n;                       // expected item count
	int          value_errors;
	int          timeout_errors;
	int          tick_cnt;
	logic [31:0] lfsr;

	mole_recorder_top uut (
		.clock(clock), .reset(reset),
		.upleft(pads[7]), .up(pads[6]), .upright(pads[5]), .left(pads[4]),
		.right(pads[3]), .downleft(pads[2]), .down(pads[1]), .downright(pads[0]),
		.diy_mode(diy_mode), .diy_playback(playback_level), .bram_loaded(bram_loaded),
		.diy_music_end(diy_music_end), .one_hz_enable(one_hz_enable),
		.music_address(music_address), .lookup_index(lookup_index),
		.ready_to_use(ready_to_use), .items(items), .index_location(index_location),
		.index_address(index_address), .diy_playback_mode(diy_playback_mode), .state(state)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock; // 20 ns period
	end

	// one-hertz stand-in, one tick every 8 cycles
	initial begin
		one_hz_enable = 1'b0;
		tick_cnt = 0;
		forever begin
			@(posedge clock);
			#1;
			tick_cnt++;
			one_hz_enable = (tick_cnt % 8 == 0);
		end
	end

	////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////

	task automatic step(); // next edge, then settle
		@(posedge clock);
		#1;
	endtask

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[30:0], lfsr[0]}; // one step per bit
		end
	endtask

	function automatic pad_bits_t pad_of(input mole_loc_t loc);
		return pad_bits_t'(8'h80 >> loc); // location 0 is the msb pad
	endfunction

	task automatic check_loc(input mole_loc_t got, input mole_loc_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s location %0d, expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_addr(input music_addr_t got, input music_addr_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s address %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_idx(input item_idx_t got, input item_idx_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_state(input diy_state_t got, input diy_state_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %s, expected %s", $time, what,
				got.name(), exp.name());
			value_errors++;
		end
	endtask

	task automatic check_bit(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic wait_state(input diy_state_t want, input int limit, input string what);
		int cnt;
		cnt = 0;
		while (state !== want && cnt < limit) begin
			step();
			cnt++;
		end
		if (state !== want) begin
			$display("timeout after %0d cycles waiting for %s", limit, what);
			timeout_errors++;
		end
	endtask

	task automatic wait_items(input item_idx_t want, input int limit, input string what);
		int cnt;
		cnt = 0;
		while (items !== want && cnt < limit) begin
			step();
			cnt++;
		end
		if (items !== want) begin
			$display("timeout after %0d cycles waiting for %s", limit, what);
			timeout_errors++;
		end
	endtask

	// one random pad press, address held steady over the write edge
	task automatic record_press();
		logic [31:0] r;
		mole_loc_t   loc;
		int          hold;
		take_bits(3, r);
		loc = r[2:0];
		take_bits(23, r);
		music_address = r[22:0];
		take_bits(3, r);
		hold = 2 + int'(r[2:0]) % 5; // 2 to 6 cycles
		exp_loc[item_idx_t'(n)] = loc;
		exp_addr[item_idx_t'(n)] = music_address;
		pads = pad_of(loc);
		repeat (hold) step();
		pads = '0;
		n++;
		wait_items(item_idx_t'(n), 10, "items after a press");
	endtask

	task automatic check_slot(input item_idx_t slot);
		lookup_index = slot;
		step(); // one cycle lookup latency
		check_loc(index_location, exp_loc[slot], $sformatf("slot %0d", slot));
		check_addr(index_address, exp_addr[slot], $sformatf("slot %0d", slot));
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		logic [31:0] r;
		mole_loc_t   a;
		mole_loc_t   b;
		int          k;
		lfsr = 32'h6d20;
		n = 0;
		value_errors = 0;
		timeout_errors = 0;
		reset = 1'b1;
		pads = '0;
		diy_mode = 1'b0;
		playback_level = 1'b0;
		bram_loaded = 1'b0;
		diy_music_end = 1'b0;
		music_address = '0;
		lookup_index = '0;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		step();
		check_state(state, diy_idle, "state after reset");
		check_idx(items, '0, "items after reset");
		check_bit(ready_to_use, 1'b0, "ready_to_use after reset");
		check_bit(diy_playback_mode, 1'b0, "diy_playback_mode after reset");

		// up held across both phases, so entering stores nothing
		diy_mode = 1'b1;
		pads = pad_of(LOC_UP);
		repeat (4) step();
		check_state(state, diy_idle, "state with music not loaded");
		bram_loaded = 1'b1;
		wait_state(diy_start, 10, "diy_start on entry");
		pads = '0;
		step();
		check_idx(items, '0, "items on entry");

		record_press();
		check_state(state, diy_hold, "state after a press");
		take_bits(3, r);
		pads = pad_of(r[2:0]); // lost, hold-off still running
		repeat (2) step();
		pads = '0;
		wait_state(diy_start, 40, "diy_start after hold-off");
		check_idx(items, item_idx_t'(n), "items after press in hold");
		check_slot('0);

		// two pads at once never count
		take_bits(3, r);
		a = r[2:0];
		take_bits(3, r);
		k = 1 + int'(r[2:0]) % 7;
		b = mole_loc_t'((int'(a) + k) % 8);
		pads = pad_of(a) | pad_of(b);
		repeat (3) step();
		pads = '0;
		repeat (4) step();
		check_idx(items, item_idx_t'(n), "items after two-pad press");
		check_state(state, diy_start, "state after two-pad press");

		// fill the table
		while (n < int'(MAX_ITEMS)) begin
			record_press();
			if (n < int'(MAX_ITEMS)) wait_state(diy_start, 40, "diy_start after hold-off");
		end
		wait_state(diy_done, 10, "diy_done on full table");
		check_bit(ready_to_use, 1'b1, "ready_to_use on full table");
		check_idx(items, MAX_ITEMS, "items on full table");
		for (int i = 0; i < int'(MAX_ITEMS); i++) check_slot(item_idx_t'(i));

		playback_level = 1'b1;
		wait_state(mole_pkg::diy_playback, 5, "diy_playback");
		check_bit(diy_playback_mode, 1'b1, "diy_playback_mode in playback");
		playback_level = 1'b0;
		wait_state(diy_done, 5, "diy_done after playback");
		check_bit(diy_playback_mode, 1'b0, "diy_playback_mode after playback");

		// leave and come back, up held again so nothing is stored
		pads = pad_of(LOC_UP);
		diy_mode = 1'b0;
		wait_state(diy_idle, 5, "diy_idle on leaving");
		n = 0;
		check_idx(items, '0, "items in idle");
		diy_mode = 1'b1;
		wait_state(diy_start, 10, "diy_start on re-entry");
		pads = '0;
		diy_music_end = 1'b1;
		wait_state(diy_done, 10, "diy_done on music end");
		check_bit(ready_to_use, 1'b1, "ready_to_use on music end");
		check_idx(items, '0, "items on music end");
		diy_music_end = 1'b0;
		step();

		$display("errors: %0d value, %0d timeout, %0d assertion",
			value_errors, timeout_errors, uut.u_assert.fail_count);
		if (value_errors + timeout_errors + uut.u_assert.fail_count == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// ==== files.f ====
mole_pkg.sv
pad_capture.sv
diy_sequencer.sv
mole_table.sv
mole_recorder_top.sv
mole_recorder_assert.sv
tb_mole_recorder.sv

// ==== Makefile ====
TOP := tb_mole_recorder

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f files.f --top-module $(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^RESULT: PASS$$"

clean:
	rm -rf obj_dir
